//--- rtl/pat_pkg.sv
package pat_pkg;

	// ========================================================================
	// widths and types
	// ========================================================================
	localparam int INSTR_WIDTH    = 20;
	localparam int PC_WIDTH       = 10;
	localparam int DATA_WIDTH     = 8;
	localparam int DMEM_DEPTH     = 32;
	localparam int DMEM_ADR_WIDTH = 5;   // low bits of the immediate
	localparam int FIELDP_WIDTH   = 5;
	localparam int BUFP_WIDTH     = 3;
	localparam int FIELD_LATENCY  = 4;   // fieldp -> fieldwp, cycles
	localparam int SHIFT_WIDTH    = 3;   // shift amount from operand b

	typedef logic [INSTR_WIDTH-1:0]    instr_t;
	typedef logic [PC_WIDTH-1:0]       pc_t;
	typedef logic [DATA_WIDTH-1:0]     data_t;
	typedef logic [DMEM_ADR_WIDTH-1:0] dmem_adr_t;
	typedef logic [FIELDP_WIDTH-1:0]   fieldp_t;
	typedef logic [BUFP_WIDTH-1:0]     bufp_t;

	// instruction word layout
	localparam int FIELDP_LSB   = 15;  // 19..15 field pointer
	localparam int FIELD_OP_BIT = 12;  // 1 = result goes to field
	localparam int OPC_WIDTH    = 4;
	localparam int OPC_I8_LSB   = 8;   // 11..8
	localparam int OPC_I3_LSB   = 4;   // 7..4
	localparam int OPC_I0_LSB   = 0;   // 3..0
	localparam int IMM3_WIDTH   = 3;   // 2..0

	// nop in i0 space, condition and pointer zero
	localparam instr_t INSTR_NOP = 20'h00fff;

	// ========================================================================
	// opcodes
	// ========================================================================
	typedef enum logic [OPC_WIDTH-1:0] {
		I8_OR = 4'h0, I8_AND = 4'h1, I8_ADDM = 4'h2, I8_SUBM = 4'h3,
		I8_ADD = 4'h4, I8_SUB = 4'h5, I8_LDI = 4'h6, I8_LDM = 4'h7,
		I8_BF = 4'h8, I8_BB = 4'h9, I8_CALL = 4'ha, I8_STAM = 4'hb,
		I8_SETSP = 4'hc, I8_ORM = 4'hd, I8_ANDM = 4'he, I8_PREFIX_I3 = 4'hf
	} op_i8_e;

	typedef enum logic [OPC_WIDTH-1:0] {
		I3_SHL = 4'h0, I3_SHLO = 4'h1, I3_SHR = 4'h2, I3_ASR = 4'h3,
		I3_IN = 4'h5, I3_OUT = 4'h8, I3_SETB = 4'h9, I3_PREFIX_I0 = 4'hf
	} op_i3_e;

	typedef enum logic [OPC_WIDTH-1:0] {
		I0_NOT = 4'h0,
		I0_NOP = 4'hf
	} op_i0_e;

	// stage 2 operation
	typedef enum logic [3:0] {
		ALU_OR, ALU_AND, ALU_NOT, ALU_ADD, ALU_SUB,
		ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR, ALU_PASS_B
	} alu_op_e;

endpackage

//--- rtl/pat_alu.sv
module pat_alu (
	input  pat_pkg::data_t   i_a,
	input  pat_pkg::data_t   i_b,
	input  pat_pkg::alu_op_e i_op,
	output pat_pkg::data_t   o_y
);
	import pat_pkg::*;

	logic [SHIFT_WIDTH-1:0] sh;   // shift amount
	data_t                  ones_fill;
	data_t                  sum;
	data_t                  diff;

	assign sh        = i_b[SHIFT_WIDTH-1:0];
	assign ones_fill = ~({DATA_WIDTH{1'b1}} << sh); // low sh bits set
	assign sum       = i_a + i_b;  // wraps mod 256
	assign diff      = i_a - i_b;

	always_comb
	begin
		case (i_op)
			ALU_OR:   o_y = i_a | i_b;
			ALU_AND:  o_y = i_a & i_b;
			ALU_NOT:  o_y = ~i_a;
			ALU_ADD:  o_y = sum;
			ALU_SUB:  o_y = diff;
			ALU_SHL:  o_y = i_a << sh;
			ALU_SHLO: o_y = (i_a << sh) | ones_fill;   // shift in ones
			ALU_SHR:  o_y = i_a >> sh;
			ALU_ASR:  o_y = data_t'($signed(i_a) >>> sh); // sign kept
			default:  o_y = i_b;                     // pass b
		endcase
	end

endmodule

//--- rtl/pat_data_mem.sv
module pat_data_mem (
	input  logic               clk,
	input  pat_pkg::dmem_adr_t i_read_adr,
	input  logic               i_write_en,
	input  pat_pkg::dmem_adr_t i_write_adr,
	input  pat_pkg::data_t     i_write_data,
	output pat_pkg::data_t     o_read_data
);
	import pat_pkg::*;

	data_t mem [DMEM_DEPTH];

	// async read, same cycle as decode
	assign o_read_data = mem[i_read_adr];

	always_ff @(posedge clk)
	begin
		if (i_write_en)
			mem[i_write_adr] <= i_write_data;
	end

endmodule

//--- rtl/pat_program_counter.sv
module pat_program_counter (
	input  logic           clk,
	input  logic           reset,
	input  logic           i_branch_fwd,
	input  logic           i_branch_back,
	input  pat_pkg::data_t i_branch_offset,
	output pat_pkg::pc_t   o_pc
);
	import pat_pkg::*;

	pc_t offset;

	// offset zero-extended to pc width
	assign offset = {{(PC_WIDTH-DATA_WIDTH){1'b0}}, i_branch_offset};

	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_branch_fwd)
			o_pc <= o_pc + offset;  // bf
		else if (i_branch_back)
			o_pc <= o_pc - offset;  // bb
		else
			o_pc <= o_pc + 1'b1;
	end

endmodule

//--- rtl/pat_decoder.sv
module pat_decoder (
	input  logic               clk,
	input  logic               reset,
	input  pat_pkg::instr_t    i_instruction,
	input  pat_pkg::data_t     i_read_data,
	output pat_pkg::dmem_adr_t o_read_adr,
	output logic               o_branch_fwd,
	output logic               o_branch_back,
	output pat_pkg::data_t     o_branch_offset,
	output pat_pkg::alu_op_e   o_alu_op,
	output pat_pkg::data_t     o_operand_b,
	output logic               o_src_in,
	output logic               o_dest_acc,
	output logic               o_dest_field,
	output logic               o_store,
	output pat_pkg::dmem_adr_t o_store_adr,
	output logic               o_store_field,
	output logic               o_out,
	output logic               o_setb,
	output pat_pkg::fieldp_t   o_fieldp,
	output pat_pkg::fieldp_t   o_fieldwp
);
	import pat_pkg::*;

	instr_t  instr_q;                          // stage 1 instruction
	fieldp_t fieldp_hist [FIELD_LATENCY];      // write pointer delay line
	logic    field_op;
	op_i8_e  opc_i8;
	op_i3_e  opc_i3;
	op_i0_e  opc_i0;
	data_t   imm8;
	logic [IMM3_WIDTH-1:0] imm3;
	data_t   imm_ext;
	logic    is_i8, is_i3, is_i0;
	logic    dest_reg, src_mem;
	alu_op_e alu_op;

	// field split
	assign field_op = instr_q[FIELD_OP_BIT];
	assign opc_i8   = op_i8_e'(instr_q[OPC_I8_LSB +: OPC_WIDTH]);
	assign opc_i3   = op_i3_e'(instr_q[OPC_I3_LSB +: OPC_WIDTH]);
	assign opc_i0   = op_i0_e'(instr_q[OPC_I0_LSB +: OPC_WIDTH]);
	assign imm8     = instr_q[DATA_WIDTH-1:0];
	assign imm3     = instr_q[IMM3_WIDTH-1:0];

	// class through the prefix chain
	assign is_i8 = (opc_i8 != I8_PREFIX_I3);
	assign is_i3 = !is_i8 && (opc_i3 != I3_PREFIX_I0);
	assign is_i0 = !is_i8 && !is_i3;

	assign imm_ext = is_i8 ? imm8 : {{(DATA_WIDTH-IMM3_WIDTH){1'b0}}, imm3};

	// ops that commit to acc or field
	assign dest_reg = (is_i8 && (opc_i8 inside {I8_OR, I8_AND, I8_ADD, I8_SUB, I8_LDI,
		I8_LDM, I8_ADDM, I8_SUBM, I8_ORM, I8_ANDM}))
		|| (is_i3 && (opc_i3 inside {I3_SHL, I3_SHLO, I3_SHR, I3_ASR, I3_IN}))
		|| (is_i0 && (opc_i0 == I0_NOT));
	assign src_mem = is_i8 && (opc_i8 inside {I8_LDM, I8_ADDM, I8_SUBM, I8_ORM, I8_ANDM});

	// memory read and branch go out combinationally
	assign o_read_adr      = instr_q[DMEM_ADR_WIDTH-1:0];
	assign o_branch_fwd    = is_i8 && (opc_i8 == I8_BF);
	assign o_branch_back   = is_i8 && (opc_i8 == I8_BB);
	assign o_branch_offset = imm8;
	assign o_fieldwp       = fieldp_hist[FIELD_LATENCY-1];

	always_comb
	begin
		alu_op = ALU_PASS_B; // ldi, ldm, in and non-alu ops
		if (is_i8)
			case (opc_i8)
				I8_OR, I8_ORM:   alu_op = ALU_OR;
				I8_AND, I8_ANDM: alu_op = ALU_AND;
				I8_ADD, I8_ADDM: alu_op = ALU_ADD;
				I8_SUB, I8_SUBM: alu_op = ALU_SUB;
				default:         alu_op = ALU_PASS_B;
			endcase
		else if (is_i3)
			case (opc_i3)
				I3_SHL:  alu_op = ALU_SHL;
				I3_SHLO: alu_op = ALU_SHLO;
				I3_SHR:  alu_op = ALU_SHR;
				I3_ASR:  alu_op = ALU_ASR;
				default: alu_op = ALU_PASS_B;
			endcase
		else if (opc_i0 == I0_NOT)
			alu_op = ALU_NOT;
	end

	// ========================================================================
	// stage 1 -> stage 2 control
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			instr_q       <= INSTR_NOP;
			o_alu_op      <= ALU_PASS_B;
			o_src_in      <= 1'b0;
			o_dest_acc    <= 1'b0;
			o_dest_field  <= 1'b0;
			o_store       <= 1'b0;
			o_store_field <= 1'b0;
			o_out         <= 1'b0;
			o_setb        <= 1'b0;
			o_fieldp      <= '0;
			fieldp_hist   <= '{default: '0};
		end
		else
		begin
			instr_q       <= i_instruction;
			o_alu_op      <= alu_op;
			o_src_in      <= is_i3 && (opc_i3 == I3_IN);
			o_dest_acc    <= dest_reg && !field_op;
			o_dest_field  <= dest_reg && field_op; // bit 12 routes to field
			o_store       <= is_i8 && (opc_i8 == I8_STAM);
			o_store_field <= field_op;             // stam source select
			o_out         <= is_i3 && (opc_i3 == I3_OUT);
			o_setb        <= is_i3 && (opc_i3 == I3_SETB);
			o_fieldp      <= instr_q[FIELDP_LSB +: FIELDP_WIDTH];
			fieldp_hist[0] <= o_fieldp;
			for (int i = 1; i < FIELD_LATENCY; i++)
				fieldp_hist[i] <= fieldp_hist[i-1];
		end
	end

	// operand b preselected, mem word or immediate
	always_ff @(posedge clk)
	begin
		o_operand_b <= src_mem ? i_read_data : imm_ext;
		o_store_adr <= instr_q[DMEM_ADR_WIDTH-1:0];
	end

endmodule

//--- rtl/pat_execute.sv
module pat_execute (
	input  logic               clk,
	input  logic               reset,
	input  pat_pkg::alu_op_e   i_alu_op,
	input  pat_pkg::data_t     i_operand_b,
	input  logic               i_src_in,
	input  logic               i_dest_acc,
	input  logic               i_dest_field,
	input  logic               i_store,
	input  pat_pkg::dmem_adr_t i_store_adr,
	input  logic               i_store_field,
	input  logic               i_out,
	input  logic               i_setb,
	input  pat_pkg::data_t     i_field,
	input  pat_pkg::data_t     i_inputs,
	output pat_pkg::data_t     o_field_out,
	output logic               o_field_write_en,
	output logic               o_write_en,
	output pat_pkg::dmem_adr_t o_write_adr,
	output pat_pkg::data_t     o_write_data,
	output pat_pkg::data_t     o_outputs,
	output pat_pkg::bufp_t     o_bufp
);
	import pat_pkg::*;

	data_t acc;          // main accumulator
	data_t acc_alu_y;
	data_t field_alu_y;
	data_t acc_result;
	data_t field_result;

	// one alu per destination, no input mux
	pat_alu u_acc_alu (
		.i_a  (acc),
		.i_b  (i_operand_b),
		.i_op (i_alu_op),
		.o_y  (acc_alu_y)
	);

	pat_alu u_field_alu (
		.i_a  (i_field),
		.i_b  (i_operand_b),
		.i_op (i_alu_op),
		.o_y  (field_alu_y)
	);

	assign acc_result   = i_src_in ? i_inputs : acc_alu_y;   // in overrides alu
	assign field_result = i_src_in ? i_inputs : field_alu_y;

	// ========================================================================
	// commit
	// ========================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc              <= '0;
			o_field_out      <= '0;
			o_field_write_en <= 1'b0;
			o_write_en       <= 1'b0;
			o_outputs        <= '0;
			o_bufp           <= '0;
		end
		else
		begin
			if (i_dest_acc)
				acc <= acc_result;
			if (i_dest_field)
				o_field_out <= field_result;
			o_field_write_en <= i_dest_field;  // one-cycle pulse
			o_write_en       <= i_store;
			if (i_out)
				o_outputs <= acc;
			if (i_setb)
				o_bufp <= i_operand_b[BUFP_WIDTH-1:0];
		end
	end

	// store request, array written one edge later
	always_ff @(posedge clk)
	begin
		if (i_store)
		begin
			o_write_adr  <= i_store_adr;
			o_write_data <= i_store_field ? i_field : acc;
		end
	end

endmodule

//--- rtl/pat_core.sv
module pat_core (
	input  logic             clk,
	input  logic             reset,
	input  pat_pkg::instr_t  i_instruction,
	input  pat_pkg::data_t   i_field,
	input  pat_pkg::data_t   i_inputs,
	output pat_pkg::pc_t     o_pc,
	output pat_pkg::bufp_t   o_bufp,
	output pat_pkg::fieldp_t o_fieldp,
	output pat_pkg::fieldp_t o_fieldwp,
	output logic             o_field_write_en,
	output pat_pkg::data_t   o_field_out,
	output pat_pkg::data_t   o_outputs
);
	import pat_pkg::*;

	// decode <-> pc / dmem
	dmem_adr_t read_adr;
	data_t     read_data;
	logic      branch_fwd, branch_back;
	data_t     branch_offset;
	// stage 1 -> stage 2
	alu_op_e   alu_op;
	data_t     operand_b;
	logic      src_in, dest_acc, dest_field;
	logic      store, store_field, out_en, setb;
	dmem_adr_t store_adr;
	// stage 2 -> dmem
	logic      dmem_write_en;
	dmem_adr_t dmem_write_adr;
	data_t     dmem_write_data;

	// ========================================================================
	// stage 1
	// ========================================================================
	pat_decoder u_decoder (
		.clk (clk), .reset (reset),
		.i_instruction (i_instruction), .i_read_data (read_data),
		.o_read_adr (read_adr),
		.o_branch_fwd (branch_fwd), .o_branch_back (branch_back),
		.o_branch_offset (branch_offset),
		.o_alu_op (alu_op), .o_operand_b (operand_b), .o_src_in (src_in),
		.o_dest_acc (dest_acc), .o_dest_field (dest_field),
		.o_store (store), .o_store_adr (store_adr), .o_store_field (store_field),
		.o_out (out_en), .o_setb (setb),
		.o_fieldp (o_fieldp), .o_fieldwp (o_fieldwp)
	);

	pat_program_counter u_pc (
		.clk (clk), .reset (reset),
		.i_branch_fwd (branch_fwd), .i_branch_back (branch_back),
		.i_branch_offset (branch_offset), .o_pc (o_pc)
	);

	pat_data_mem u_dmem (
		.clk (clk), .i_read_adr (read_adr),
		.i_write_en (dmem_write_en), .i_write_adr (dmem_write_adr),
		.i_write_data (dmem_write_data), .o_read_data (read_data)
	);

	// ========================================================================
	// stage 2
	// ========================================================================
	pat_execute u_execute (
		.clk (clk), .reset (reset),
		.i_alu_op (alu_op), .i_operand_b (operand_b), .i_src_in (src_in),
		.i_dest_acc (dest_acc), .i_dest_field (dest_field),
		.i_store (store), .i_store_adr (store_adr), .i_store_field (store_field),
		.i_out (out_en), .i_setb (setb),
		.i_field (i_field), .i_inputs (i_inputs),
		.o_field_out (o_field_out), .o_field_write_en (o_field_write_en),
		.o_write_en (dmem_write_en), .o_write_adr (dmem_write_adr),
		.o_write_data (dmem_write_data),
		.o_outputs (o_outputs), .o_bufp (o_bufp)
	);

endmodule

//--- sim/pat_props.sv
module pat_props (
	input logic             clk,
	input logic             reset,
	input pat_pkg::fieldp_t i_fieldp,
	input pat_pkg::fieldp_t i_fieldwp,
	input logic             i_field_write_en,
	input logic             i_mem_write_en
);
	timeunit 1ns;
	timeprecision 1ps;
	import pat_pkg::*;

	// write pointer trails the field pointer
	assert property (@(posedge clk) disable iff (reset)
		i_fieldwp == $past(i_fieldp, FIELD_LATENCY))
	else
		$error("o_fieldwp differs from o_fieldp of %0d cycles before", FIELD_LATENCY);

	// no write strobe straight out of reset
	assert property (@(posedge clk) reset |=> !i_field_write_en)
	else
		$error("o_field_write_en high in the cycle after reset");

	assert property (@(posedge clk) reset |=> !i_mem_write_en)
	else
		$error("data memory write enable high in the cycle after reset");

endmodule

bind pat_core pat_props u_props (
	.clk (clk), .reset (reset),
	.i_fieldp (o_fieldp), .i_fieldwp (o_fieldwp),
	.i_field_write_en (o_field_write_en), .i_mem_write_en (dmem_write_en)
);

//--- sim/pat_tb.sv
module pat_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import pat_pkg::*;

	localparam int TEST_CYCLES    = 150;                     // about the sum of all tests
	localparam int TIMEOUT_CYCLES = (TEST_CYCLES + 50) * 10; // 2000

	logic    clk, reset;
	instr_t  i_instruction;
	data_t   i_field, i_inputs;
	pc_t     o_pc;
	bufp_t   o_bufp;
	fieldp_t o_fieldp, o_fieldwp;
	logic    o_field_write_en;
	data_t   o_field_out, o_outputs;

	// reference model
	data_t   model_acc;
	data_t   model_mem [DMEM_DEPTH];
	pc_t     model_pc;
	instr_t  prev_instr;   // sits in the decode stage
	int      n_checks = 0, n_errors = 0, n_tests = 0, err_base = 0, cycles = 0;

	pat_core i_dut (.*);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	initial
	begin
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("run stopped, tests still busy after %0d cycles", cycles);
		$display("test failed");
		$finish;
	end

	// ========================================================================
	// instruction encoding and model rules
	// ========================================================================
	function automatic instr_t encode_i8(op_i8_e op, data_t imm, logic fld, fieldp_t fp);
		return {fp, 2'b00, fld, op, imm};
	endfunction

	function automatic instr_t encode_i3(op_i3_e op, logic [2:0] imm, logic fld, fieldp_t fp);
		return {fp, 2'b00, fld, 4'hf, op, 1'b0, imm};   // i3 prefix in 11..8
	endfunction

	function automatic instr_t encode_i0(op_i0_e op, logic fld, fieldp_t fp);
		return {fp, 2'b00, fld, 8'hff, op};              // both prefixes
	endfunction

	function automatic data_t model_alu(alu_op_e op, data_t a, data_t b);
		data_t r;
		r = a;
		case (op)
			ALU_OR:   r = a | b;
			ALU_AND:  r = a & b;
			ALU_NOT:  r = ~a;
			ALU_ADD:  r = data_t'(int'(a) + int'(b));   // mod 256
			ALU_SUB:  r = data_t'(int'(a) - int'(b));
			ALU_SHL:  r = a << b[2:0];
			ALU_SHR:  r = a >> b[2:0];
			ALU_SHLO:
				repeat (b[2:0])
					r = {r[6:0], 1'b1};               // ones come in at the bottom
			ALU_ASR:
				repeat (b[2:0])
					r = {r[7], r[7:1]};
			default:  r = b;                         // ldi, ldm, in
		endcase
		return r;
	endfunction

	// one instruction per edge, inputs move 10 ns after it
	task automatic issue(input instr_t instr);
		op_i8_e prev_op;
		i_instruction = instr;
		@(posedge clk);
		prev_op = op_i8_e'(prev_instr[11:8]);   // decoded in the cycle just ended
		if (prev_op == I8_BF)
			model_pc = model_pc + pc_t'(prev_instr[7:0]);
		else if (prev_op == I8_BB)
			model_pc = model_pc - pc_t'(prev_instr[7:0]);
		else
			model_pc = model_pc + 1;
		prev_instr = instr;
		#10;
	endtask

	task automatic idle(input int n);
		repeat (n)
			issue(encode_i0(I0_NOP, 1'b0, '0));
	endtask

	// ========================================================================
	// compare tasks
	// ========================================================================
	task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		n_checks++;
		if (got !== exp)
		begin
			n_errors++;
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
		end
	endtask
	task automatic check_data(input string name, input data_t got, input data_t exp);
		compare_value(name, 32'(got), 32'(exp));
	endtask
	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		compare_value(name, 32'(got), 32'(exp));
	endtask
	task automatic check_fieldp(input string name, input fieldp_t got, input fieldp_t exp);
		compare_value(name, 32'(got), 32'(exp));
	endtask
	task automatic check_bufp(input string name, input bufp_t got, input bufp_t exp);
		compare_value(name, 32'(got), 32'(exp));
	endtask
	task automatic check_bit(input string name, input logic got, input logic exp);
		compare_value(name, 32'(got), 32'(exp));
	endtask

	// out lands on o_outputs two edges later
	task automatic output_and_check();
		issue(encode_i3(I3_OUT, 3'd0, 1'b0, '0));
		idle(2);
		check_data("o_outputs", o_outputs, model_acc);
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		$display("[%s] done, %0d errors", name, n_errors - err_base);
		err_base = n_errors;
	endtask

	// ========================================================================
	// directed tests
	// ========================================================================
	task automatic test_reset_count();
		check_pc("o_pc", o_pc, '0);
		check_data("o_outputs", o_outputs, '0);
		check_data("o_field_out", o_field_out, '0);
		check_bufp("o_bufp", o_bufp, '0);
		check_fieldp("o_fieldp", o_fieldp, '0);
		check_fieldp("o_fieldwp", o_fieldwp, '0);
		check_bit("o_field_write_en", o_field_write_en, 1'b0);
		for (int i = 1; i <= 8; i++)
		begin
			idle(1);
			check_pc("o_pc", o_pc, pc_t'(i));   // one step per cycle
		end
		finish_test("reset_count");
	endtask

	task automatic test_acc_alu();
		alu_op_e    ops [9] = '{ALU_ADD, ALU_SUB, ALU_OR, ALU_AND, ALU_NOT,
			ALU_SHL, ALU_SHLO, ALU_SHR, ALU_ASR};
		instr_t     op_instr;
		data_t      b;
		foreach (ops[i])
		begin
			b = data_t'($urandom);
			model_acc = data_t'($urandom);
			issue(encode_i8(I8_LDI, model_acc, 1'b0, '0));
			case (ops[i])
				ALU_ADD: op_instr = encode_i8(I8_ADD, b, 1'b0, '0);
				ALU_SUB: op_instr = encode_i8(I8_SUB, b, 1'b0, '0);
				ALU_OR:  op_instr = encode_i8(I8_OR, b, 1'b0, '0);
				ALU_AND: op_instr = encode_i8(I8_AND, b, 1'b0, '0);
				ALU_NOT: op_instr = encode_i0(I0_NOT, 1'b0, '0);
				ALU_SHL: op_instr = encode_i3(I3_SHL, b[2:0], 1'b0, '0);
				ALU_SHLO: op_instr = encode_i3(I3_SHLO, b[2:0], 1'b0, '0);
				ALU_SHR: op_instr = encode_i3(I3_SHR, b[2:0], 1'b0, '0);
				default: op_instr = encode_i3(I3_ASR, b[2:0], 1'b0, '0);
			endcase
			issue(op_instr);   // back to back on the ldi
			model_acc = model_alu(ops[i], model_acc, b);
			output_and_check();
		end
		finish_test("acc_alu");
	endtask

	task automatic test_memory();
		op_i8_e    mops [4] = '{I8_ADDM, I8_SUBM, I8_ORM, I8_ANDM};
		alu_op_e   aops [4] = '{ALU_ADD, ALU_SUB, ALU_OR, ALU_AND};
		dmem_adr_t adr [2];
		adr[0] = dmem_adr_t'($urandom);
		adr[1] = adr[0] + 1'b1;
		for (int k = 0; k < 2; k++)
		begin
			model_acc = data_t'($urandom);
			issue(encode_i8(I8_LDI, model_acc, 1'b0, '0));
			issue(encode_i8(I8_STAM, data_t'(adr[k]), 1'b0, '0));
			model_mem[adr[k]] = model_acc;
		end
		idle(3);   // no forwarding, store must land first
		issue(encode_i8(I8_LDM, data_t'(adr[0]), 1'b0, '0));
		model_acc = model_mem[adr[0]];
		output_and_check();
		foreach (mops[i])
		begin
			issue(encode_i8(mops[i], data_t'(adr[(i + 1) % 2]), 1'b0, '0));
			model_acc = model_alu(aops[i], model_acc, model_mem[adr[(i + 1) % 2]]);
			output_and_check();
		end
		finish_test("memory");
	endtask

	task automatic test_field_path();
		alu_op_e   ops [4] = '{ALU_ADD, ALU_AND, ALU_SHR, ALU_PASS_B};
		data_t     b;
		fieldp_t   fp;
		dmem_adr_t a;
		i_field = data_t'($urandom);   // held for the whole test
		foreach (ops[i])
		begin
			b = data_t'($urandom);
			fp = fieldp_t'($urandom_range(31, 1));
			case (ops[i])
				ALU_ADD: issue(encode_i8(I8_ADD, b, 1'b1, fp));
				ALU_AND: issue(encode_i8(I8_AND, b, 1'b1, fp));
				ALU_SHR: issue(encode_i3(I3_SHR, b[2:0], 1'b1, fp));
				default: issue(encode_i8(I8_LDI, b, 1'b1, fp));
			endcase
			idle(1);   // E+1
			check_fieldp("o_fieldp", o_fieldp, fp);
			check_bit("o_field_write_en", o_field_write_en, 1'b0);
			idle(1);   // E+2, commit
			check_bit("o_field_write_en", o_field_write_en, 1'b1);
			check_data("o_field_out", o_field_out, model_alu(ops[i], i_field, b));
			idle(1);
			check_bit("o_field_write_en", o_field_write_en, 1'b0);   // single pulse
			idle(2);   // E+5
			check_fieldp("o_fieldwp", o_fieldwp, fp);
		end
		output_and_check();   // acc untouched by field ops
		a = dmem_adr_t'($urandom);
		issue(encode_i8(I8_STAM, data_t'(a), 1'b1, '0));   // stores i_field
		model_mem[a] = i_field;
		idle(3);
		issue(encode_i8(I8_LDM, data_t'(a), 1'b0, '0));
		model_acc = model_mem[a];
		output_and_check();
		finish_test("field_path");
	endtask

	task automatic test_branch_in_setb();
		pc_t   p0;
		data_t k;
		bufp_t bsel;
		k = data_t'($urandom_range(200, 2));
		issue(encode_i8(I8_BF, k, 1'b0, '0));
		p0 = model_pc;
		idle(1);
		check_pc("o_pc", o_pc, pc_t'(p0 + k));
		k = data_t'($urandom_range(200, 2));
		issue(encode_i8(I8_BB, k, 1'b0, '0));
		p0 = model_pc;
		idle(1);
		check_pc("o_pc", o_pc, pc_t'(p0 - k));
		idle(2);
		check_pc("o_pc", o_pc, model_pc);   // whole run tracked
		i_inputs = data_t'($urandom);
		issue(encode_i3(I3_IN, 3'd0, 1'b0, '0));
		model_acc = i_inputs;
		output_and_check();
		bsel = bufp_t'($urandom_range(7, 1));   // nonzero, differs from reset
		issue(encode_i3(I3_SETB, bsel, 1'b0, '0));
		idle(2);
		check_bufp("o_bufp", o_bufp, bsel);
		finish_test("branch_in_setb");
	endtask

	// ========================================================================
	// main sequence
	// ========================================================================
	initial
	begin
		void'($urandom(32'h90e5));
		reset = 1'b1;
		i_instruction = encode_i0(I0_NOP, 1'b0, '0);
		i_field = '0;
		i_inputs = '0;
		model_acc = '0;
		model_pc = '0;
		prev_instr = i_instruction;   // decoder holds a nop in reset
		repeat (5) @(posedge clk);
		#10 reset = 1'b0;
		test_reset_count();
		test_acc_alu();
		test_memory();
		test_field_path();
		test_branch_in_setb();
		$display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
		if (n_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

//--- build.f
rtl/pat_pkg.sv
rtl/pat_alu.sv
rtl/pat_data_mem.sv
rtl/pat_program_counter.sv
rtl/pat_decoder.sv
rtl/pat_execute.sv
rtl/pat_core.sv
sim/pat_props.sv
sim/pat_tb.sv

//--- Makefile
TOP = pat_tb

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module $(TOP) -f build.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; st=$$?; cat sim.log; exit $$st
	! grep -q "test failed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean
